// File: sgd_gradient.f
verilog/sgd_pkg.sv
verilog/sgd_read_sequencer.sv
verilog/sgd_loss_stage.sv
verilog/sgd_masked_add_tree.sv
verilog/sgd_bit_accumulator.sv
verilog/sgd_gradient.sv
tb/tb_sgd_gradient.sv

// File: Makefile
# Verilator build and run for the sgd_gradient testbench

VERILATOR ?= verilator
TOP       ?= tb_sgd_gradient
FILELIST  ?= sgd_gradient.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_sgd_gradient.sv
`timescale 1ns/10ps

module tb_sgd_gradient import sgd_pkg::*;;

    localparam int num_banks   = 4;
    localparam int lanes       = 8;
    localparam int chunk_size  = num_banks * lanes;
    localparam int plane_depth = 1024;
    localparam int num_cases   = 6;
    // loss modes of the case table
    localparam int mode_random = 0;
    localparam int mode_neg    = 1;
    localparam int mode_zero   = 2;

    logic                         clk;
    logic                         rst_n;
    logic [31:0]                  dimension;
    logic [5:0]                   number_of_bits;
    loss_t [num_banks-1:0]        loss_in;
    logic                         loss_valid;
    logic                         fifo_rd_en;
    logic [chunk_size-1:0]        fifo_rd_data = '0;
    loss_t [lanes-1:0]            gradient_out;
    logic                         gradient_valid;

    // case table: name, dimension, bit planes, loss mode
    string case_name [num_cases] = '{"one_chunk_8b", "three_half_chunks", "single_bit",
                                     "neg_sparse", "zero_loss", "empty_dim"};
    int    case_dim  [num_cases] = '{32, 112, 40, 64, 20, 0};
    int    case_bits [num_cases] = '{8, 6, 1, 16, 4, 8};
    int    case_mode [num_cases] = '{mode_random, mode_random, mode_random,
                                     mode_neg, mode_zero, mode_random};

    // fifo model contents, read in order by a running pointer
    logic [chunk_size-1:0] planes [plane_depth];
    int                    rd_ptr = 0;
    int                    rd_count = 0;
    logic                  rd_seen = 1'b0;

    loss_t [num_banks-1:0] cur_loss;
    int                    cur_bits;
    int                    case_base;
    logic [31:0]           rng_state = 32'd88;
    int                    error_count = 0;
    int                    check_count = 0;
    logic                  timed_out = 1'b0;

    sgd_gradient #(
        .num_banks (num_banks),
        .lanes     (lanes)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .dimension      (dimension),
        .number_of_bits (number_of_bits),
        .loss_in        (loss_in),
        .loss_valid     (loss_valid),
        .fifo_rd_en     (fifo_rd_en),
        .fifo_rd_data   (fifo_rd_data),
        .gradient_out   (gradient_out),
        .gradient_valid (gradient_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // word for a read in cycle t shows up during cycle t+2
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_seen <= 1'b0;
        end else begin
            rd_seen <= fifo_rd_en;
            if (fifo_rd_en) begin
                rd_count <= rd_count + 1;
            end
            if (rd_seen) begin
                fifo_rd_data <= planes[rd_ptr];
                rd_ptr       <= (rd_ptr + 1) % plane_depth;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // gradient of one lane in one chunk, built up plane by plane
    function automatic loss_t expected_gradient(input int lane, input int chunk);
        logic signed [35:0]    acc;
        logic signed [35:0]    part;
        logic signed [31:0]    sum;
        logic [chunk_size-1:0] word;
        acc = '0;
        for (int k = 0; k < cur_bits; k++) begin
            word = planes[(case_base + chunk * cur_bits + k) % plane_depth];
            sum = '0;
            for (int j = 0; j < num_banks; j++) begin
                if (word[lane + j * lanes]) begin
                    sum = sum + cur_loss[j];
                end
            end
            // 4 guard bits, then weight 2^-(k+1)
            part = $signed({{4{sum[31]}}, sum}) * 36'sd16;
            part = part >>> (k + 1);
            if (k == 0) begin
                acc = part + 36'sd11;
            end else if (part != -36'sd1) begin
                acc = acc + part;
            end
        end
        acc = acc >>> 4;
        return acc[31:0];
    endfunction

    task automatic check_result(input int c, input int chunk);
        loss_t exp_val;
        for (int lane = 0; lane < lanes; lane++) begin
            exp_val = expected_gradient(lane, chunk);
            check_count++;
            assert (gradient_out[lane] == exp_val) else begin
                $display("FAILED %s lane %0d chunk %0d expected %0d actual %0d",
                         case_name[c], lane, chunk, exp_val, gradient_out[lane]);
                error_count++;
            end
        end
    endtask

    // no reads and no results may appear in this window
    task automatic check_quiet(input string name, input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            check_count++;
            assert (!fifo_rd_en && !gradient_valid) else begin
                $display("%s: fifo read or gradient pulse seen while idle", name);
                error_count++;
            end
        end
    endtask

    task automatic run_case(input int c);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        int          chunks;
        int          count_before;
        int          got;
        int          cycles;
        int          limit;
        cur_bits  = case_bits[c];
        chunks    = (case_dim[c] + chunk_size - 1) / chunk_size;
        case_base = rd_ptr;
        // bit planes for this run, sparse ones for the negative case
        for (int n = 0; n < chunks * cur_bits; n++) begin
            draw_random(r1);
            draw_random(r2);
            draw_random(r3);
            planes[(case_base + n) % plane_depth] = (case_mode[c] == mode_neg) ?
                (r1 & r2 & r3) : r1;
        end
        for (int j = 0; j < num_banks; j++) begin
            draw_random(r1);
            if (case_mode[c] == mode_neg) begin
                // small negatives so that late partials reach minus one
                cur_loss[j] = -32'sd1 - $signed({24'd0, r1[7:0]});
            end else if (case_mode[c] == mode_zero) begin
                cur_loss[j] = '0;
            end else begin
                cur_loss[j] = $signed(r1) >>> 3;
            end
        end
        count_before = rd_count;
        @(posedge clk);
        dimension      <= 32'(case_dim[c]);
        number_of_bits <= 6'(cur_bits);
        loss_in        <= cur_loss;
        loss_valid     <= 1'b1;
        @(posedge clk);
        loss_valid <= 1'b0;
        // results come back in chunk order
        got    = 0;
        cycles = 0;
        limit  = chunks * cur_bits + 64;
        while (!(got == chunks && !fifo_rd_en) && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (gradient_valid) begin
                check_result(c, got);
                got++;
            end
        end
        if (cycles >= limit) begin
            $display("%s: timeout, got %0d of %0d gradient pulses", case_name[c], got, chunks);
            error_count++;
            timed_out = 1'b1;
        end else begin
            check_quiet(case_name[c], 16);
            check_count++;
            assert (rd_count - count_before == chunks * cur_bits) else begin
                $display("FAILED %s read count expected %0d actual %0d", case_name[c],
                         chunks * cur_bits, rd_count - count_before);
                error_count++;
            end
        end
    endtask

    initial begin
        rst_n          <= 1'b0;
        dimension      <= '0;
        number_of_bits <= 6'd8;
        loss_in        <= '0;
        loss_valid     <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        check_quiet("after_reset", 12);
        for (int c = 0; c < num_cases && !timed_out; c++) begin
            run_case(c);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/sgd_gradient.sv
`timescale 1ns/10ps

module sgd_gradient import sgd_pkg::*; #(
    parameter int num_banks = 4,
    parameter int lanes     = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [31:0]                   dimension,
    input  logic [5:0]                    number_of_bits,
    input  loss_t [num_banks-1:0]         loss_in,
    input  logic                          loss_valid,
    output logic                          fifo_rd_en,
    input  logic [lanes*num_banks-1:0]    fifo_rd_data,
    output loss_t [lanes-1:0]             gradient_out,
    output logic                          gradient_valid
);

    plane_tag_t            seq_tag;
    plane_tag_t            plane_tag;
    loss_t [num_banks-1:0] stage_loss;

    // chunk and bit plane walk
    sgd_read_sequencer #(
        .num_banks (num_banks),
        .lanes     (lanes)
    ) u_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .loss_valid     (loss_valid),
        .dimension      (dimension),
        .number_of_bits (number_of_bits),
        .fifo_rd_en     (fifo_rd_en),
        .seq_tag        (seq_tag)
    );

    // loss hold and tag alignment to fifo data
    sgd_loss_stage #(
        .num_banks (num_banks)
    ) u_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .loss_in    (loss_in),
        .loss_valid (loss_valid),
        .seq_tag    (seq_tag),
        .stage_loss (stage_loss),
        .plane_tag  (plane_tag)
    );

    for (genvar i = 0; i < lanes; i++) begin : g_lane
        logic [num_banks-1:0] lane_bits;
        loss_t                lane_sum;
        plane_tag_t           tree_tag;

        // feature bit of lane i in bank j sits at i + j*lanes
        for (genvar j = 0; j < num_banks; j++) begin : g_bit
            assign lane_bits[j] = fifo_rd_data[i + j*lanes];
        end

        sgd_masked_add_tree #(
            .num_banks (num_banks)
        ) u_tree (
            .clk          (clk),
            .rst_n        (rst_n),
            .stage_loss   (stage_loss),
            .feature_bits (lane_bits),
            .plane_tag    (plane_tag),
            .lane_sum     (lane_sum),
            .tree_tag     (tree_tag)
        );

        // all lanes run in lockstep, lane 0 speaks for them
        if (i == 0) begin : g_lead
            sgd_bit_accumulator u_acc (
                .clk            (clk),
                .rst_n          (rst_n),
                .lane_sum       (lane_sum),
                .tree_tag       (tree_tag),
                .gradient       (gradient_out[i]),
                .gradient_valid (gradient_valid)
            );
        end else begin : g_follow
            sgd_bit_accumulator u_acc (
                .clk            (clk),
                .rst_n          (rst_n),
                .lane_sum       (lane_sum),
                .tree_tag       (tree_tag),
                .gradient       (gradient_out[i]),
                .gradient_valid ()
            );
        end
    end

endmodule

// File: verilog/sgd_bit_accumulator.sv
`timescale 1ns/10ps

module sgd_bit_accumulator import sgd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  loss_t      lane_sum,
    input  plane_tag_t tree_tag,
    output loss_t      gradient,
    output logic       gradient_valid
);

    // stage 0, combinational weighting
    wide_acc_t  sum_ext;
    wide_acc_t  sum_shift;
    logic [5:0] shift_amt;

    // stage 1 registers
    wide_acc_t  shift_q;
    logic       minus_one_q;
    logic       valid_q;
    logic       first_q;
    logic       last_q;

    // stage 2 registers
    wide_acc_t  acc_q;
    logic       done_q;

    // guard bits below the loss lsb
    assign sum_ext = wide_acc_t'({lane_sum, {guard_bits{1'b0}}});

    // weight of bit k is 2^-(k+1)
    assign shift_amt = 6'(tree_tag.bit_index) + 6'd1;
    assign sum_shift = sum_ext >>> shift_amt;

    always_ff @(posedge clk) begin
        shift_q     <= sum_shift;
        // all ones, a small negative rest that is dropped later
        minus_one_q <= (sum_shift == '1);
        first_q     <= tree_tag.first;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= tree_tag.valid;
            last_q  <= tree_tag.valid & tree_tag.last;
        end
    end

    // accumulate planes of one chunk
    always_ff @(posedge clk) begin
        if (valid_q) begin
            if (first_q) begin
                // first plane restarts the sum with the rounding bias
                acc_q <= shift_q + wide_acc_t'(round_bias);
            end else if (minus_one_q) begin
                acc_q <= acc_q;
            end else begin
                acc_q <= acc_q + shift_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= last_q;
        end
    end

    // stage 3, strip the guard bits
    always_ff @(posedge clk) begin
        gradient <= loss_t'(acc_q >>> guard_bits);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gradient_valid <= 1'b0;
        end else begin
            gradient_valid <= done_q;
        end
    end

    // planes of a chunk arrive back to back, bit index counting up from 0
    a_plane_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        tree_tag.valid |-> (tree_tag.first
            || tree_tag.bit_index == $past(tree_tag.bit_index) + 5'd1)
    );

endmodule

// File: verilog/sgd_masked_add_tree.sv
`timescale 1ns/10ps

module sgd_masked_add_tree import sgd_pkg::*; #(
    parameter int num_banks = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  loss_t [num_banks-1:0]   stage_loss,
    input  logic [num_banks-1:0]    feature_bits,
    input  plane_tag_t              plane_tag,
    output loss_t                   lane_sum,
    output plane_tag_t              tree_tag
);

    // adder levels after the mask stage
    localparam int levels = $clog2(num_banks);

    // pairwise reduction needs a power of two
    if ((1 << levels) != num_banks) begin : g_bank_check
        $error("sgd_masked_add_tree: num_banks must be a power of two");
    end

    // level 0 holds the masked losses, each later level halves the count
    for (genvar l = 0; l <= levels; l++) begin : g_lvl
        localparam int width = num_banks >> l;
        loss_t [width-1:0] sum_q;

        if (l == 0) begin : g_mask
            // zero where the feature bit is clear
            always_ff @(posedge clk) begin
                for (int j = 0; j < width; j++) begin
                    sum_q[j] <= feature_bits[j] ? stage_loss[j] : '0;
                end
            end
        end else begin : g_add
            // wraps at 32 bits like the loss itself
            always_ff @(posedge clk) begin
                for (int j = 0; j < width; j++) begin
                    sum_q[j] <= g_lvl[l-1].sum_q[2*j] + g_lvl[l-1].sum_q[2*j+1];
                end
            end
        end
    end

    assign lane_sum = g_lvl[levels].sum_q[0];

    // tag follows the data through every level
    plane_tag_t tag_pipe [levels+1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i <= levels; i++) begin
                tag_pipe[i].valid <= 1'b0;
            end
        end else begin
            tag_pipe[0] <= plane_tag;
            for (int i = 1; i <= levels; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign tree_tag = tag_pipe[levels];

endmodule

// File: verilog/sgd_loss_stage.sv
`timescale 1ns/10ps

module sgd_loss_stage import sgd_pkg::*; #(
    parameter int num_banks = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  loss_t [num_banks-1:0]   loss_in,
    input  logic                    loss_valid,
    input  plane_tag_t              seq_tag,
    output loss_t [num_banks-1:0]   stage_loss,
    output plane_tag_t              plane_tag
);

    // tag delay line, one entry per cycle of fifo latency
    plane_tag_t tag_pipe [fifo_read_latency];

    // losses stay fixed for the whole sample
    always_ff @(posedge clk) begin
        if (loss_valid) begin
            stage_loss <= loss_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < fifo_read_latency; i++) begin
                tag_pipe[i].valid <= 1'b0;
            end
        end else begin
            tag_pipe[0] <= seq_tag;
            for (int i = 1; i < fifo_read_latency; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    // lines up with fifo_rd_data
    assign plane_tag = tag_pipe[fifo_read_latency-1];

endmodule

// File: verilog/sgd_read_sequencer.sv
`timescale 1ns/10ps

module sgd_read_sequencer import sgd_pkg::*; #(
    parameter int num_banks = 4,
    parameter int lanes     = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        loss_valid,
    input  logic [31:0] dimension,
    input  logic [5:0]  number_of_bits,
    output logic        fifo_rd_en,
    output plane_tag_t  seq_tag
);

    // features covered by one fifo word
    localparam int chunk_words = num_banks * lanes;

    seq_state_t  state_q;
    seq_state_t  state_d;
    chunk_cnt_t  chunk_left;
    chunk_cnt_t  chunk_d;
    chunk_cnt_t  chunk_total;
    bit_idx_t    bit_idx;
    bit_idx_t    bit_d;
    bit_idx_t    bits_m1;
    bit_idx_t    bits_m1_d;
    logic [31:0] chunk_quot;
    logic        chunk_rem;

    // ceil(dimension / chunk_words)
    assign chunk_quot  = dimension / 32'(chunk_words);
    assign chunk_rem   = (dimension % 32'(chunk_words)) != '0;
    assign chunk_total = chunk_cnt_t'(chunk_quot) + chunk_cnt_t'(chunk_rem);

    // registers describe the read issued in the current cycle
    always_comb begin
        state_d   = state_q;
        chunk_d   = chunk_left;
        bit_d     = bit_idx;
        bits_m1_d = bits_m1;
        case (state_q)
            idle: begin
                // empty dimension means no reads at all
                if (loss_valid && chunk_total != '0) begin
                    state_d   = run;
                    chunk_d   = chunk_total;
                    bit_d     = '0;
                    bits_m1_d = bit_idx_t'(number_of_bits - 6'd1);
                end
            end
            run: begin
                if (bit_idx == bits_m1) begin
                    // chunk done, move on or stop
                    bit_d = '0;
                    if (chunk_left == chunk_cnt_t'(1)) begin
                        state_d = idle;
                    end else begin
                        chunk_d = chunk_left - chunk_cnt_t'(1);
                    end
                end else begin
                    bit_d = bit_idx + bit_idx_t'(1);
                end
            end
            default: begin
                state_d = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= idle;
            chunk_left <= '0;
            bit_idx    <= '0;
            bits_m1    <= '0;
            fifo_rd_en <= 1'b0;
            seq_tag    <= '0;
        end else begin
            state_q           <= state_d;
            chunk_left        <= chunk_d;
            bit_idx           <= bit_d;
            bits_m1           <= bits_m1_d;
            // one read per cycle for the whole run
            fifo_rd_en        <= (state_d == run);
            seq_tag.valid     <= (state_d == run);
            seq_tag.bit_index <= bit_d;
            seq_tag.first     <= (bit_d == '0);
            seq_tag.last      <= (bit_d == bits_m1_d);
        end
    end

    // a new sample may only arrive once the run is over
    a_no_strobe_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == run) |-> !loss_valid
    );

endmodule

// File: verilog/sgd_pkg.sv
package sgd_pkg;

    // scaled loss of one bank, also used for the lane gradient
    typedef logic signed [31:0] loss_t;

    // accumulator with fraction guard bits below the loss lsb
    typedef logic signed [35:0] wide_acc_t;

    // quantization bit index, up to 32 planes
    typedef logic [4:0] bit_idx_t;

    // chunks left in the current run
    typedef logic [11:0] chunk_cnt_t;

    // sideband that rides along with every bit plane
    typedef struct packed {
        logic     valid;
        bit_idx_t bit_index;
        // bit index zero of a chunk
        logic     first;
        // final bit plane of a chunk
        logic     last;
    } plane_tag_t;

    // read sequencer FSM
    typedef enum logic {
        idle,
        run
    } seq_state_t;

    // fraction bits kept below the loss during accumulation
    localparam int guard_bits = 4;

    // rounding bias, added once per chunk on the first plane
    localparam int round_bias = 11;

    // cycles from fifo_rd_en to valid fifo_rd_data
    localparam int fifo_read_latency = 2;

endpackage
